/* compile.f */
hw/rv_pkg.sv
hw/rv_cmpitag.sv
hw/rv_bus_latch.sv
hw/rv_entry.sv
hw/rv_select.sv
hw/rv_station.sv
verif/tb_rv_station.sv

/* run.sh */
#!/bin/sh
# Builds the reservation station testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_rv_station -f compile.f

out=$(./obj_dir/Vtb_rv_station)
echo "$out"

if ! echo "$out" | grep -q "All checks passed"; then
   exit 1
fi

/* verif/tb_rv_station.sv */
// Reservation station testbench
// Directed tests for dispatch, wakeup on the completion buses, thread
// filtering, abort cancel and lowest-index issue, checked cycle by cycle
// against the station timing rules

`timescale 1ns/1ps
`default_nettype none

module tb_rv_station;

   localparam int CLK_PERIOD = 100;
   localparam int NUM_TESTS = 5;

   logic                                                clk;
   logic                                                rst_n;
   logic                                                disp_vld;
   logic [0:rv_pkg::THREADS-1]                          disp_thread;
   logic [0:rv_pkg::ITAG_SIZE-1]                        disp_itag;
   logic                                                disp_s1_vld;
   logic [0:rv_pkg::ITAG_SIZE-1]                        disp_s1_itag;
   logic                                                disp_s2_vld;
   logic [0:rv_pkg::ITAG_SIZE-1]                        disp_s2_itag;
   logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::THREADS)-1]   cmp_vld_ary;
   logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::ITAG_SIZE)-1] cmp_itag_ary;
   logic [0:rv_pkg::Q_ITAG_BUSSES-1]                    cmp_abort;
   logic                                                full;
   logic                                                issue_vld;
   logic [0:rv_pkg::ITAG_SIZE-1]                        issue_itag;
   logic [0:rv_pkg::THREADS-1]                          issue_thread;
   logic [0:rv_pkg::ENTRIES-1]                          cancel_mask;

   int pass_count = 0;
   int fail_count = 0;
   logic [31:0] rng_state = 32'h5dc7fca6;
   logic [0:rv_pkg::ITAG_SIZE-1] used_itags[$];

   // Completion bus contents as broadcast in the wakeup test
   logic [0:rv_pkg::ITAG_SIZE-1] bus_itag [0:rv_pkg::Q_ITAG_BUSSES-1];
   logic [0:rv_pkg::THREADS-1]   bus_mask [0:rv_pkg::Q_ITAG_BUSSES-1];

   rv_station i_rv_station
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_vld     (disp_vld),
      .disp_thread  (disp_thread),
      .disp_itag    (disp_itag),
      .disp_s1_vld  (disp_s1_vld),
      .disp_s1_itag (disp_s1_itag),
      .disp_s2_vld  (disp_s2_vld),
      .disp_s2_itag (disp_s2_itag),
      .cmp_vld_ary  (cmp_vld_ary),
      .cmp_itag_ary (cmp_itag_ary),
      .cmp_abort    (cmp_abort),
      .full         (full),
      .issue_vld    (issue_vld),
      .issue_itag   (issue_itag),
      .issue_thread (issue_thread),
      .cancel_mask  (cancel_mask)
   );

   initial
   begin
      clk = 1'b0;
   end

   always #(CLK_PERIOD/2) clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Draws a random itag that no earlier test has used
   function automatic logic [0:rv_pkg::ITAG_SIZE-1] fresh_itag();
      logic [0:rv_pkg::ITAG_SIZE-1] cand;
      logic clash;
      cand  = '0;
      clash = 1'b1;
      while (clash)
      begin
         rng_state = xorshift(rng_state);
         cand      = rng_state[rv_pkg::ITAG_SIZE-1:0];
         clash     = 1'b0;
         foreach (used_itags[i])
         begin
            if (used_itags[i] == cand)
            begin
               clash = 1'b1;
            end
         end
      end
      used_itags.push_back(cand);
      return cand;
   endfunction

   // A source is ready if it was not needed or a normal completion matched it
   function automatic logic source_ready(input logic v, input logic [0:rv_pkg::ITAG_SIZE-1] src,
                                         input logic [0:rv_pkg::THREADS-1] thr);
      logic hit;
      hit = 1'b0;
      for (int n = 0; n < rv_pkg::Q_ITAG_BUSSES; n++)
      begin
         if (bus_itag[n] == src && (bus_mask[n] & thr) != '0)
         begin
            hit = 1'b1;
         end
      end
      return !v || hit;
   endfunction

   task automatic tick();
      @(posedge clk);
      #1;
   endtask

   task automatic dispatch(input logic [0:rv_pkg::THREADS-1] thr,
                           input logic [0:rv_pkg::ITAG_SIZE-1] it,
                           input logic v1, input logic [0:rv_pkg::ITAG_SIZE-1] i1,
                           input logic v2, input logic [0:rv_pkg::ITAG_SIZE-1] i2);
      disp_vld     = 1'b1;
      disp_thread  = thr;
      disp_itag    = it;
      disp_s1_vld  = v1;
      disp_s1_itag = i1;
      disp_s2_vld  = v2;
      disp_s2_itag = i2;
      tick();
      disp_vld = 1'b0;
   endtask

   task automatic set_bus(input int n, input logic [0:rv_pkg::THREADS-1] mask,
                          input logic [0:rv_pkg::ITAG_SIZE-1] it, input logic abrt);
      cmp_vld_ary[n*rv_pkg::THREADS +: rv_pkg::THREADS]      = mask;
      cmp_itag_ary[n*rv_pkg::ITAG_SIZE +: rv_pkg::ITAG_SIZE] = it;
      cmp_abort[n]                                           = abrt;
   endtask

   // The buses are sampled at the next edge and then dropped
   task automatic pulse_buses();
      tick();
      cmp_vld_ary  = '0;
      cmp_itag_ary = '0;
      cmp_abort    = '0;
   endtask

   task automatic check_issue(input logic exp_vld, input logic [0:rv_pkg::ITAG_SIZE-1] exp_itag,
                              input logic [0:rv_pkg::THREADS-1] exp_thread);
      if (issue_vld !== exp_vld)
      begin
         $display("[FAIL] t=%0t issue_vld got %b exp %b", $time, issue_vld, exp_vld);
         fail_count++;
      end
      else if (exp_vld && issue_itag !== exp_itag)
      begin
         $display("[FAIL] t=%0t issue_itag got %h exp %h", $time, issue_itag, exp_itag);
         fail_count++;
      end
      else if (exp_vld && issue_thread !== exp_thread)
      begin
         $display("[FAIL] t=%0t issue_thread got %b exp %b", $time, issue_thread, exp_thread);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   task automatic check_cancel(input logic [0:rv_pkg::ENTRIES-1] exp_mask);
      if (cancel_mask !== exp_mask)
      begin
         $display("[FAIL] t=%0t cancel_mask got %b exp %b", $time, cancel_mask, exp_mask);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   task automatic check_full(input logic exp_full);
      if (full !== exp_full)
      begin
         $display("[FAIL] t=%0t full got %b exp %b", $time, full, exp_full);
         fail_count++;
      end
      else
      begin
         pass_count++;
      end
   endtask

   task automatic finish_test(input string name, input int start);
      if (fail_count == start)
      begin
         $display("test %s: ok", name);
      end
      else
      begin
         $display("test %s: %0d errors", name, fail_count - start);
      end
   endtask

   task automatic test_no_source_fill();
      logic [0:rv_pkg::ITAG_SIZE-1] it [0:rv_pkg::ENTRIES-1];
      logic [0:rv_pkg::THREADS-1]   thr [0:rv_pkg::ENTRIES-1];
      logic [0:rv_pkg::ITAG_SIZE-1] x;
      int start;
      start = fail_count;
      it[0] = fresh_itag();
      dispatch(2'b10, it[0], 1'b0, '0, 1'b0, '0);
      check_issue(1'b0, '0, '0);
      tick();
      check_issue(1'b1, it[0], 2'b10);
      tick();
      check_issue(1'b0, '0, '0);
      // All four wait on one shared tag so that the station fills up
      x = fresh_itag();
      for (int e = 0; e < rv_pkg::ENTRIES; e++)
      begin
         it[e]  = fresh_itag();
         thr[e] = (e % 2 == 0) ? 2'b10 : 2'b01;
         check_full(1'b0);
         dispatch(thr[e], it[e], 1'b1, x, 1'b0, '0);
      end
      check_full(1'b1);
      set_bus(0, 2'b11, x, 1'b0);
      pulse_buses();
      check_issue(1'b0, '0, '0);
      tick();
      check_issue(1'b0, '0, '0);
      for (int e = 0; e < rv_pkg::ENTRIES; e++)
      begin
         tick();
         check_issue(1'b1, it[e], thr[e]);
      end
      tick();
      check_issue(1'b0, '0, '0);
      check_full(1'b0);
      finish_test("no_source_fill", start);
   endtask

   task automatic test_two_sources();
      logic [0:rv_pkg::ITAG_SIZE-1] it;
      logic [0:rv_pkg::ITAG_SIZE-1] s1;
      logic [0:rv_pkg::ITAG_SIZE-1] s2;
      int start;
      start = fail_count;
      it = fresh_itag();
      s1 = fresh_itag();
      s2 = fresh_itag();
      dispatch(2'b01, it, 1'b1, s1, 1'b1, s2);
      tick();
      check_issue(1'b0, '0, '0);
      set_bus(1, 2'b01, s1, 1'b0);
      pulse_buses();
      repeat (3)
      begin
         tick();
         check_issue(1'b0, '0, '0);
      end
      set_bus(2, 2'b01, s2, 1'b0);
      pulse_buses();
      tick();
      check_issue(1'b0, '0, '0);
      tick();
      check_issue(1'b1, it, 2'b01);
      tick();
      check_issue(1'b0, '0, '0);
      finish_test("two_sources", start);
   endtask

   task automatic test_thread_filter();
      logic [0:rv_pkg::ITAG_SIZE-1] it;
      logic [0:rv_pkg::ITAG_SIZE-1] x;
      int start;
      start = fail_count;
      it = fresh_itag();
      x  = fresh_itag();
      dispatch(2'b10, it, 1'b1, x, 1'b0, '0);
      set_bus(0, 2'b01, x, 1'b0);
      pulse_buses();
      repeat (4)
      begin
         tick();
         check_issue(1'b0, '0, '0);
      end
      set_bus(2, 2'b10, x, 1'b0);
      pulse_buses();
      tick();
      check_issue(1'b0, '0, '0);
      tick();
      check_issue(1'b1, it, 2'b10);
      tick();
      check_issue(1'b0, '0, '0);
      finish_test("thread_filter", start);
   endtask

   task automatic test_abort_cancel();
      logic [0:rv_pkg::ITAG_SIZE-1] ia;
      logic [0:rv_pkg::ITAG_SIZE-1] ib;
      logic [0:rv_pkg::ITAG_SIZE-1] x;
      logic [0:rv_pkg::ITAG_SIZE-1] y;
      int start;
      start = fail_count;
      ia = fresh_itag();
      ib = fresh_itag();
      x  = fresh_itag();
      y  = fresh_itag();
      dispatch(2'b10, ia, 1'b1, x, 1'b0, '0);
      dispatch(2'b10, ib, 1'b0, '0, 1'b1, y);
      set_bus(1, 2'b10, x, 1'b1);
      pulse_buses();
      check_cancel('0);
      tick();
      check_cancel(4'b1000);
      check_issue(1'b0, '0, '0);
      repeat (4)
      begin
         tick();
         check_cancel('0);
         check_issue(1'b0, '0, '0);
      end
      set_bus(0, 2'b10, y, 1'b0);
      pulse_buses();
      tick();
      check_issue(1'b0, '0, '0);
      tick();
      check_issue(1'b1, ib, 2'b10);
      tick();
      check_issue(1'b0, '0, '0);
      finish_test("abort_cancel", start);
   endtask

   task automatic test_multi_bus_wakeup();
      logic [0:rv_pkg::ITAG_SIZE-1] pool [0:3];
      logic [0:rv_pkg::ITAG_SIZE-1] e_itag [0:rv_pkg::ENTRIES-1];
      logic [0:rv_pkg::THREADS-1]   e_thread [0:rv_pkg::ENTRIES-1];
      logic [0:rv_pkg::ITAG_SIZE-1] e_s1 [0:rv_pkg::ENTRIES-1];
      logic [0:rv_pkg::ITAG_SIZE-1] e_s2 [0:rv_pkg::ENTRIES-1];
      logic [0:rv_pkg::ENTRIES-1]   e_v1;
      logic [0:rv_pkg::ENTRIES-1]   e_v2;
      logic [0:rv_pkg::ENTRIES-1]   ready;
      int start;
      start = fail_count;
      for (int i = 0; i < 4; i++)
      begin
         pool[i] = fresh_itag();
      end
      // Entry 2 waits on pool[3], which the three buses never carry
      e_v1     = 4'b1110;
      e_v2     = 4'b1011;
      e_s1     = '{pool[0], pool[2], pool[1], pool[0]};
      e_s2     = '{pool[1], pool[3], pool[3], pool[0]};
      e_thread = '{2'b10, 2'b01, 2'b10, 2'b01};
      bus_itag = '{pool[0], pool[1], pool[2]};
      bus_mask = '{2'b11, 2'b10, 2'b01};
      for (int e = 0; e < rv_pkg::ENTRIES; e++)
      begin
         e_itag[e] = fresh_itag();
         dispatch(e_thread[e], e_itag[e], e_v1[e], e_s1[e], e_v2[e], e_s2[e]);
         ready[e] = source_ready(e_v1[e], e_s1[e], e_thread[e]) &
                    source_ready(e_v2[e], e_s2[e], e_thread[e]);
      end
      check_full(1'b1);
      for (int n = 0; n < rv_pkg::Q_ITAG_BUSSES; n++)
      begin
         set_bus(n, bus_mask[n], bus_itag[n], 1'b0);
      end
      pulse_buses();
      tick();
      check_issue(1'b0, '0, '0);
      for (int e = 0; e < rv_pkg::ENTRIES; e++)
      begin
         if (ready[e])
         begin
            tick();
            check_issue(1'b1, e_itag[e], e_thread[e]);
         end
      end
      tick();
      check_issue(1'b0, '0, '0);
      set_bus(0, 2'b11, pool[3], 1'b0);
      pulse_buses();
      tick();
      tick();
      check_issue(1'b1, e_itag[2], e_thread[2]);
      tick();
      check_issue(1'b0, '0, '0);
      check_full(1'b0);
      finish_test("multi_bus_wakeup", start);
   endtask

   initial
   begin
      rst_n        = 1'b0;
      disp_vld     = 1'b0;
      disp_thread  = '0;
      disp_itag    = '0;
      disp_s1_vld  = 1'b0;
      disp_s1_itag = '0;
      disp_s2_vld  = 1'b0;
      disp_s2_itag = '0;
      cmp_vld_ary  = '0;
      cmp_itag_ary = '0;
      cmp_abort    = '0;
      repeat (8) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_issue(1'b0, '0, '0);
      check_cancel('0);
      check_full(1'b0);
      test_no_source_fill();
      test_two_sources();
      test_thread_filter();
      test_abort_cancel();
      test_multi_bus_wakeup();
      $display("summary: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0)
      begin
         $display("All checks passed");
      end
      else
      begin
         $display("Checks failed");
      end
      $finish;
   end

   // Each test gets a budget of 200 clock cycles
   initial
   begin
      #(NUM_TESTS * 200 * CLK_PERIOD);
      $display("watchdog expired before the tests finished");
      $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

/* hw/rv_station.sv */
// Instruction reservation station
// Latches up to three completion buses, wakes the waiting sources of four
// entries, cancels entries hit by an aborted completion and issues the
// lowest ready entry each cycle. Dispatch fills the lowest free entry.

`timescale 1ns/1ps
`default_nettype none

module rv_station
(
   input  logic                                                clk,
   input  logic                                                rst_n,

   input  logic                                                disp_vld,
   input  logic [0:rv_pkg::THREADS-1]                          disp_thread,
   input  logic [0:rv_pkg::ITAG_SIZE-1]                        disp_itag,
   input  logic                                                disp_s1_vld,
   input  logic [0:rv_pkg::ITAG_SIZE-1]                        disp_s1_itag,
   input  logic                                                disp_s2_vld,
   input  logic [0:rv_pkg::ITAG_SIZE-1]                        disp_s2_itag,

   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::THREADS)-1]   cmp_vld_ary,
   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::ITAG_SIZE)-1] cmp_itag_ary,
   input  logic [0:rv_pkg::Q_ITAG_BUSSES-1]                    cmp_abort,

   output logic                                                full,
   output logic                                                issue_vld,
   output logic [0:rv_pkg::ITAG_SIZE-1]                        issue_itag,
   output logic [0:rv_pkg::THREADS-1]                          issue_thread,
   output logic [0:rv_pkg::ENTRIES-1]                          cancel_mask
);

   // Latched completion buses broadcast to every entry
   logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::THREADS)-1]   lat_vld_ary;
   logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::ITAG_SIZE)-1] lat_itag_ary;
   logic [0:rv_pkg::Q_ITAG_BUSSES-1]                    lat_abort;

   // Entry state seen by the selector
   logic [0:rv_pkg::ENTRIES-1]                     ent_valid;
   logic [0:rv_pkg::ENTRIES-1]                     ent_rdy;
   logic [0:(rv_pkg::ENTRIES*rv_pkg::ITAG_SIZE)-1] ent_itag;
   logic [0:(rv_pkg::ENTRIES*rv_pkg::THREADS)-1]   ent_thread;

   // One-hot strobes from the selector
   logic [0:rv_pkg::ENTRIES-1] alloc;
   logic [0:rv_pkg::ENTRIES-1] issue_grant;

   genvar e;

   rv_bus_latch i_rv_bus_latch
   (
      .clk         (clk),
      .rst_n       (rst_n),
      .vld_ary_in  (cmp_vld_ary),
      .itag_ary_in (cmp_itag_ary),
      .abort_in    (cmp_abort),
      .vld_ary     (lat_vld_ary),
      .itag_ary    (lat_itag_ary),
      .abort       (lat_abort)
   );

   generate
      for (e = 0; e < rv_pkg::ENTRIES; e = e + 1)
      begin : g_entry
         rv_entry i_rv_entry
         (
            .clk          (clk),
            .rst_n        (rst_n),
            .alloc        (alloc[e]),
            .issue_grant  (issue_grant[e]),
            .disp_thread  (disp_thread),
            .disp_itag    (disp_itag),
            .disp_s1_vld  (disp_s1_vld),
            .disp_s1_itag (disp_s1_itag),
            .disp_s2_vld  (disp_s2_vld),
            .disp_s2_itag (disp_s2_itag),
            .vld_ary      (lat_vld_ary),
            .itag_ary     (lat_itag_ary),
            .abort        (lat_abort),
            .valid        (ent_valid[e]),
            .rdy          (ent_rdy[e]),
            .itag         (ent_itag[e*rv_pkg::ITAG_SIZE +: rv_pkg::ITAG_SIZE]),
            .thread       (ent_thread[e*rv_pkg::THREADS +: rv_pkg::THREADS]),
            .cancel       (cancel_mask[e])
         );
      end
   endgenerate

   rv_select i_rv_select
   (
      .clk          (clk),
      .rst_n        (rst_n),
      .disp_vld     (disp_vld),
      .valid        (ent_valid),
      .rdy          (ent_rdy),
      .itag         (ent_itag),
      .thread       (ent_thread),
      .alloc        (alloc),
      .issue_grant  (issue_grant),
      .full         (full),
      .issue_vld    (issue_vld),
      .issue_itag   (issue_itag),
      .issue_thread (issue_thread)
   );

endmodule

`default_nettype wire

/* hw/rv_select.sv */
// Reservation station selector
// Picks the lowest free entry for dispatch and the lowest valid ready entry
// for issue, and registers the issuing itag and thread onto the outputs

`timescale 1ns/1ps
`default_nettype none

module rv_select
(
   input  logic                                            clk,
   input  logic                                            rst_n,
   input  logic                                            disp_vld,
   input  logic [0:rv_pkg::ENTRIES-1]                      valid,
   input  logic [0:rv_pkg::ENTRIES-1]                      rdy,
   input  logic [0:(rv_pkg::ENTRIES*rv_pkg::ITAG_SIZE)-1]  itag,
   input  logic [0:(rv_pkg::ENTRIES*rv_pkg::THREADS)-1]    thread,
   output logic [0:rv_pkg::ENTRIES-1]                      alloc,
   output logic [0:rv_pkg::ENTRIES-1]                      issue_grant,
   output logic                                            full,
   output logic                                            issue_vld,
   output logic [0:rv_pkg::ITAG_SIZE-1]                    issue_itag,
   output logic [0:rv_pkg::THREADS-1]                      issue_thread
);

   logic                          free_found;
   logic                          issue_any;
   logic [rv_pkg::ENTRY_IDX-1:0]  issue_idx;

   // Two priority scans from entry 0 upward
   always_comb
   begin
      alloc       = '0;
      issue_grant = '0;
      free_found  = 1'b0;
      issue_any   = 1'b0;
      issue_idx   = '0;
      for (int e = 0; e < rv_pkg::ENTRIES; e++)
      begin
         if (!valid[e] && !free_found)
         begin
            alloc[e]   = disp_vld;
            free_found = 1'b1;
         end
         if (valid[e] && rdy[e] && !issue_any)
         begin
            issue_grant[e] = 1'b1;
            issue_any      = 1'b1;
            issue_idx      = e[rv_pkg::ENTRY_IDX-1:0];
         end
      end
   end

   assign full = &valid;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         issue_vld <= 1'b0;
      end
      else
      begin
         issue_vld <= issue_any;
      end
   end

   always_ff @(posedge clk)
   begin
      if (issue_any)
      begin
         issue_itag   <= itag[issue_idx*rv_pkg::ITAG_SIZE +: rv_pkg::ITAG_SIZE];
         issue_thread <= thread[issue_idx*rv_pkg::THREADS +: rv_pkg::THREADS];
      end
   end

endmodule

`default_nettype wire

/* hw/rv_entry.sv */
// Reservation station entry
// Holds one dispatched instruction with its thread, its itag and two source
// itags. Each pending source watches the latched completion buses. A normal
// hit marks it ready and an aborted hit cancels the entry. Issue frees it.

`timescale 1ns/1ps
`default_nettype none

module rv_entry
(
   input  logic                                                clk,
   input  logic                                                rst_n,
   input  logic                                                alloc,
   input  logic                                                issue_grant,
   input  logic [0:rv_pkg::THREADS-1]                          disp_thread,
   input  logic [0:rv_pkg::ITAG_SIZE-1]                        disp_itag,
   input  logic                                                disp_s1_vld,
   input  logic [0:rv_pkg::ITAG_SIZE-1]                        disp_s1_itag,
   input  logic                                                disp_s2_vld,
   input  logic [0:rv_pkg::ITAG_SIZE-1]                        disp_s2_itag,
   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::THREADS)-1]   vld_ary,
   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::ITAG_SIZE)-1] itag_ary,
   input  logic [0:rv_pkg::Q_ITAG_BUSSES-1]                    abort,
   output logic                                                valid,
   output logic                                                rdy,
   output logic [0:rv_pkg::ITAG_SIZE-1]                        itag,
   output logic [0:rv_pkg::THREADS-1]                          thread,
   output logic                                                cancel
);

   logic                         s1_rdy;
   logic                         s2_rdy;
   logic [0:rv_pkg::ITAG_SIZE-1] s1_itag;
   logic [0:rv_pkg::ITAG_SIZE-1] s2_itag;

   logic s1_clear;
   logic s1_abort;
   logic s2_clear;
   logic s2_abort;

   logic s1_pend;
   logic s2_pend;
   logic abort_hit;

   rv_cmpitag i_cmp_s1
   (
      .vld       (thread),
      .itag      (s1_itag),
      .vld_ary   (vld_ary),
      .itag_ary  (itag_ary),
      .abort     (abort),
      .hit_clear (s1_clear),
      .hit_abort (s1_abort)
   );

   rv_cmpitag i_cmp_s2
   (
      .vld       (thread),
      .itag      (s2_itag),
      .vld_ary   (vld_ary),
      .itag_ary  (itag_ary),
      .abort     (abort),
      .hit_clear (s2_clear),
      .hit_abort (s2_abort)
   );

   // Only a source still waiting in a live entry reacts to the buses
   assign s1_pend = valid & ~s1_rdy;
   assign s2_pend = valid & ~s2_rdy;

   assign abort_hit = (s1_pend & s1_abort) | (s2_pend & s2_abort);

   assign rdy = s1_rdy & s2_rdy;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         valid  <= 1'b0;
         s1_rdy <= 1'b0;
         s2_rdy <= 1'b0;
         cancel <= 1'b0;
      end
      else
      begin
         // One-cycle pulse in the cycle the entry drops out
         cancel <= abort_hit;

         if (alloc)
         begin
            valid  <= 1'b1;
            s1_rdy <= ~disp_s1_vld;
            s2_rdy <= ~disp_s2_vld;
         end
         else if (abort_hit || issue_grant)
         begin
            valid <= 1'b0;
         end
         else
         begin
            if (s1_pend && s1_clear)
            begin
               s1_rdy <= 1'b1;
            end
            if (s2_pend && s2_clear)
            begin
               s2_rdy <= 1'b1;
            end
         end
      end
   end

   // The instruction fields are written once at dispatch
   always_ff @(posedge clk)
   begin
      if (alloc)
      begin
         itag    <= disp_itag;
         thread  <= disp_thread;
         s1_itag <= disp_s1_itag;
         s2_itag <= disp_s2_itag;
      end
   end

endmodule

`default_nettype wire

/* hw/rv_bus_latch.sv */
// Completion bus latch
// Registers the completion buses from the top ports so that the broadcast
// to all entries starts from a flop. Valids clear on reset.

`timescale 1ns/1ps
`default_nettype none

module rv_bus_latch
(
   input  logic                                                clk,
   input  logic                                                rst_n,
   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::THREADS)-1]   vld_ary_in,
   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::ITAG_SIZE)-1] itag_ary_in,
   input  logic [0:rv_pkg::Q_ITAG_BUSSES-1]                    abort_in,
   output logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::THREADS)-1]   vld_ary,
   output logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::ITAG_SIZE)-1] itag_ary,
   output logic [0:rv_pkg::Q_ITAG_BUSSES-1]                    abort
);

   // Latched thread valids of every bus
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         vld_ary <= '0;
      end
      else
      begin
         vld_ary <= vld_ary_in;
      end
   end

   // Latched itags and abort bits of every bus
   always_ff @(posedge clk)
   begin
      itag_ary <= itag_ary_in;
      abort    <= abort_in;
   end

endmodule

`default_nettype wire

/* hw/rv_cmpitag.sv */
// Reservation station source compare
// Compares one waiting source itag against every completion bus. A bus hits
// when its itag is equal and its thread mask overlaps the source thread.
// Normal hits are ORed into hit_clear and aborted hits into hit_abort.

`timescale 1ns/1ps
`default_nettype none

module rv_cmpitag
(
   input  logic [0:rv_pkg::THREADS-1]                          vld,
   input  logic [0:rv_pkg::ITAG_SIZE-1]                        itag,
   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::THREADS)-1]   vld_ary,
   input  logic [0:(rv_pkg::Q_ITAG_BUSSES*rv_pkg::ITAG_SIZE)-1] itag_ary,
   input  logic [0:rv_pkg::Q_ITAG_BUSSES-1]                    abort,
   output logic                                                hit_clear,
   output logic                                                hit_abort
);

   // Per-bus thread overlap, itag equality and the combined hit
   logic [0:rv_pkg::Q_ITAG_BUSSES-1] bus_vld;
   logic [0:rv_pkg::Q_ITAG_BUSSES-1] bus_eq;
   logic [0:rv_pkg::Q_ITAG_BUSSES-1] bus_hit;

   // Hits split by the abort bit of their bus
   logic [0:rv_pkg::Q_ITAG_BUSSES-1] clear_hit;
   logic [0:rv_pkg::Q_ITAG_BUSSES-1] abort_hit;

   genvar n;

   generate
      for (n = 0; n < rv_pkg::Q_ITAG_BUSSES; n = n + 1)
      begin : g_bus
         // Bus n sits in slice n of the flat thread-valid and itag vectors
         assign bus_vld[n] = |(vld_ary[n*rv_pkg::THREADS +: rv_pkg::THREADS] & vld);

         assign bus_eq[n] =
            (itag_ary[n*rv_pkg::ITAG_SIZE +: rv_pkg::ITAG_SIZE] == itag);

         assign bus_hit[n] = bus_vld[n] & bus_eq[n];

         assign clear_hit[n] = bus_hit[n] & ~abort[n];
         assign abort_hit[n] = bus_hit[n] & abort[n];
      end
   endgenerate

   // Any bus may report the tag, so the hits reduce with an OR
   assign hit_clear = |clear_hit;
   assign hit_abort = |abort_hit;

endmodule

`default_nettype wire

/* hw/rv_pkg.sv */
// Reservation station package
// Sizes of the station, the thread count, the completion bus count and the
// instruction tag width shared by every block of the station

`default_nettype none

package rv_pkg;

   // Number of hardware threads in a one-hot or multi-hot thread mask
   localparam int THREADS = 2;

   // Width of an instruction tag
   localparam int ITAG_SIZE = 7;

   // Completion buses compared by every source of every entry
   localparam int Q_ITAG_BUSSES = 3;

   // Station depth and the width of an entry index
   localparam int ENTRIES = 4;
   localparam int ENTRY_IDX = 2;

endpackage

`default_nettype wire
